//--- hdl/frame_store_pkg.sv
`default_nettype none

package frame_store_pkg;

	// ======================================
	// Memory addressing
	// ======================================

	// Byte address into the frame store
	typedef logic [29:0] addr_t;

	// One frame slot is 16 MB of address space
	localparam addr_t SLOT_STRIDE = 30'h0100_0000;

	// ======================================
	// Read ports and pixel format
	// ======================================

	localparam int NUM_PORTS = 5;         // Trailing read ports

	localparam int BYTES_PER_PIXEL = 2;   // 16-bit pixels

	// Writer reports slots 0 to 7
	localparam int SLOT_ID_W = 3;

	typedef logic [SLOT_ID_W-1:0] slot_id_t;

endpackage

`default_nettype wire

//--- hdl/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

	// ======================================
	// Sync bundle
	// ======================================

	typedef struct packed {
		logic vs;   // Vertical sync
		logic hs;   // Horizontal sync
		logic de;   // Data enable, high in active video
	} sync_t;

	// Idle levels of the read timing
	localparam sync_t SYNC_RESET = '{vs: 1'b1, hs: 1'b1, de: 1'b0};

	// ======================================
	// Geometry
	// ======================================

	// Pixel or line count
	typedef logic [15:0] dim_t;

	// Assumed 720p until the first measurement lands
	localparam dim_t RESET_WIDTH  = 16'd1280;
	localparam dim_t RESET_HEIGHT = 16'd720;

endpackage

`default_nettype wire

//--- hdl/frame_buffer_ifs.sv
`default_nettype none

// ======================================
// Read-port base addresses
// ======================================

interface slot_bases_if;

	// One base per read port, index 0 is port 1
	frame_store_pkg::addr_t bases [frame_store_pkg::NUM_PORTS];

	modport src (output bases);
	modport dst (input  bases);

endinterface

// ======================================
// Raster position and geometry
// ======================================

interface raster_if;

	video_timing_pkg::sync_t sync;    // Registered sync
	logic                    de_now;  // Input DE, same cycle
	video_timing_pkg::dim_t  column;  // Pixel index in line
	video_timing_pkg::dim_t  line;    // Lines done this frame
	video_timing_pkg::dim_t  width;   // Last measured width
	video_timing_pkg::dim_t  height;  // Last measured height

	modport src (
		output sync,
		output de_now,
		output column,
		output line,
		output width,
		output height
	);

	modport dst (
		input sync,
		input de_now,
		input column,
		input line,
		input width,
		input height
	);

endinterface

`default_nettype wire

//--- hdl/frame_slot_scheduler.sv
`default_nettype none

module frame_slot_scheduler #(
	parameter int unsigned SLOT_COUNT = 6   // Physical slots in the ring
) (
	input  logic                      pix_clk_rd,
	input  logic                      reset,
	input  logic                      wr_slot_valid,
	input  frame_store_pkg::slot_id_t wr_slot,
	slot_bases_if.src                 bases
);

	// Physical slot behind the reported one
	int unsigned wr_phys;

	frame_store_pkg::addr_t base_q [frame_store_pkg::NUM_PORTS];

	// Start address of a physical slot
	function automatic frame_store_pkg::addr_t slot_base(input int unsigned slot);
		frame_store_pkg::addr_t idx;
		idx = frame_store_pkg::addr_t'(slot);
		return idx * frame_store_pkg::SLOT_STRIDE;
	endfunction

	// ======================================
	// Slot wrap
	// ======================================

	// Reports past the ring fold back onto the low slots
	always_comb
	begin
		wr_phys = wr_slot % SLOT_COUNT;
	end

	// ======================================
	// Base registers
	// ======================================

	// Port j reads slot p+j+1 around the ring, index i is port i+1
	always_ff @(posedge pix_clk_rd or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < frame_store_pkg::NUM_PORTS; i++)
			begin
				base_q[i] <= slot_base(i);   // Port j starts on slot j-1
			end
		end
		else if (wr_slot_valid)
		begin
			for (int i = 0; i < frame_store_pkg::NUM_PORTS; i++)
			begin
				base_q[i] <= slot_base((wr_phys + i + 2) % SLOT_COUNT);
			end
		end
	end

	assign bases.bases = base_q;

endmodule

`default_nettype wire

//--- hdl/raster_geometry_meter.sv
`default_nettype none

module raster_geometry_meter (
	input  logic                    pix_clk_rd,
	input  logic                    reset,
	input  video_timing_pkg::sync_t sync_in,
	raster_if.src                   raster
);

	video_timing_pkg::sync_t sync_q;

	logic de_fall;
	logic vs_fall;
	logic vs_rise;

	video_timing_pkg::dim_t column_cnt;
	video_timing_pkg::dim_t line_cnt;
	video_timing_pkg::dim_t width_q;
	video_timing_pkg::dim_t height_q;

	// ======================================
	// Sync register and edges
	// ======================================

	always_ff @(posedge pix_clk_rd or posedge reset)
	begin
		if (reset)
		begin
			sync_q <= video_timing_pkg::SYNC_RESET;
		end
		else
		begin
			sync_q <= sync_in;
		end
	end

	// Edges seen between the input and its registered copy
	assign de_fall = ~sync_in.de & sync_q.de;
	assign vs_fall = ~sync_in.vs & sync_q.vs;
	assign vs_rise =  sync_in.vs & ~sync_q.vs;

	// ======================================
	// Column and line counters
	// ======================================

	always_ff @(posedge pix_clk_rd or posedge reset)
	begin
		if (reset)
		begin
			column_cnt <= '0;
		end
		else if (de_fall)
		begin
			column_cnt <= '0;   // End of active line
		end
		else if (sync_in.de)
		begin
			column_cnt <= column_cnt + 1'b1;
		end
	end

	// Counts completed lines, restarts at frame start
	always_ff @(posedge pix_clk_rd or posedge reset)
	begin
		if (reset)
		begin
			line_cnt <= '0;
		end
		else if (vs_fall)
		begin
			line_cnt <= '0;
		end
		else if (de_fall)
		begin
			line_cnt <= line_cnt + 1'b1;
		end
	end

	// ======================================
	// Measured geometry
	// ======================================

	always_ff @(posedge pix_clk_rd or posedge reset)
	begin
		if (reset)
		begin
			width_q  <= video_timing_pkg::RESET_WIDTH;
			height_q <= video_timing_pkg::RESET_HEIGHT;
		end
		else
		begin
			if (de_fall)
				width_q <= column_cnt;   // Pixels in the line just ended
			if (vs_rise)
				height_q <= line_cnt;    // Lines in the frame just ended
		end
	end

	assign raster.sync   = sync_q;
	assign raster.de_now = sync_in.de;
	assign raster.column = column_cnt;
	assign raster.line   = line_cnt;
	assign raster.width  = width_q;
	assign raster.height = height_q;

endmodule

`default_nettype wire

//--- hdl/read_request_gen.sv
`default_nettype none

module read_request_gen (
	input  logic                                 pix_clk_rd,
	input  logic                                 reset,
	input  logic                                 read_en,
	input  logic [frame_store_pkg::NUM_PORTS-1:0] port_en,
	slot_bases_if.dst                            bases,
	raster_if.dst                                raster,
	output logic [frame_store_pkg::NUM_PORTS-1:0] req,
	output frame_store_pkg::addr_t               addr [frame_store_pkg::NUM_PORTS]
);

	// Pixel index inside the frame and its byte offset
	frame_store_pkg::addr_t pix_offset;
	frame_store_pkg::addr_t byte_offset;

	logic [frame_store_pkg::NUM_PORTS-1:0] req_next;

	// ======================================
	// Offset into the frame
	// ======================================

	always_comb
	begin
		pix_offset  = frame_store_pkg::addr_t'(raster.line)
		            * frame_store_pkg::addr_t'(raster.width)
		            + frame_store_pkg::addr_t'(raster.column);
		byte_offset = pix_offset
		            * frame_store_pkg::addr_t'(frame_store_pkg::BYTES_PER_PIXEL);
	end

	// One request per active pixel on each enabled port
	always_comb
	begin
		for (int j = 0; j < frame_store_pkg::NUM_PORTS; j++)
		begin
			req_next[j] = raster.de_now & read_en & port_en[j];
		end
	end

	// ======================================
	// Request and address registers
	// ======================================

	always_ff @(posedge pix_clk_rd or posedge reset)
	begin
		if (reset)
		begin
			req <= '0;
		end
		else
		begin
			req <= req_next;   // Lines up with the registered DE
		end
	end

	// Address only meaningful while its strobe is high
	always_ff @(posedge pix_clk_rd)
	begin
		for (int j = 0; j < frame_store_pkg::NUM_PORTS; j++)
		begin
			if (req_next[j])
			begin
				addr[j] <= bases.bases[j] + byte_offset;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/frame_buffer_read_ctrl.sv
`default_nettype none

module frame_buffer_read_ctrl #(
	parameter int unsigned SLOT_COUNT = 6
) (
	input  logic                                  pix_clk_rd,
	input  logic                                  reset,

	// Read timing
	input  logic                                  rd_vs,
	input  logic                                  rd_hs,
	input  logic                                  rd_de,

	// Slot report from the writer
	input  logic                                  wr_slot_valid,
	input  frame_store_pkg::slot_id_t             wr_slot,

	input  logic                                  read_en,
	input  logic [frame_store_pkg::NUM_PORTS-1:0] rd_port_en,

	// Registered timing
	output logic                                  out_vs,
	output logic                                  out_hs,
	output logic                                  out_de,

	output video_timing_pkg::dim_t                frame_width,
	output video_timing_pkg::dim_t                frame_height,

	// Per-port read requests
	output logic [frame_store_pkg::NUM_PORTS-1:0] rd_req,
	output frame_store_pkg::addr_t                rd_addr [frame_store_pkg::NUM_PORTS]
);

	video_timing_pkg::sync_t sync_in;

	slot_bases_if u_slot_bases ();
	raster_if     u_raster ();

	always_comb
	begin
		sync_in.vs = rd_vs;
		sync_in.hs = rd_hs;
		sync_in.de = rd_de;
	end

	// ======================================
	// Slot rotation and raster measurement
	// ======================================

	frame_slot_scheduler #(
		.SLOT_COUNT    (SLOT_COUNT)
	) u_slot_scheduler (
		.pix_clk_rd    (pix_clk_rd),
		.reset         (reset),
		.wr_slot_valid (wr_slot_valid),
		.wr_slot       (wr_slot),
		.bases         (u_slot_bases.src)
	);

	raster_geometry_meter u_raster_meter (
		.pix_clk_rd (pix_clk_rd),
		.reset      (reset),
		.sync_in    (sync_in),
		.raster     (u_raster.src)
	);

	// ======================================
	// Request generation
	// ======================================

	read_request_gen u_req_gen (
		.pix_clk_rd (pix_clk_rd),
		.reset      (reset),
		.read_en    (read_en),
		.port_en    (rd_port_en),
		.bases      (u_slot_bases.dst),
		.raster     (u_raster.dst),
		.req        (rd_req),
		.addr       (rd_addr)
	);

	// Interface fields out to plain ports
	assign out_vs       = u_raster.sync.vs;
	assign out_hs       = u_raster.sync.hs;
	assign out_de       = u_raster.sync.de;
	assign frame_width  = u_raster.width;
	assign frame_height = u_raster.height;

endmodule

`default_nettype wire

//--- tests/tb_frame_buffer_read_ctrl.sv
`default_nettype none

module tb_frame_buffer_read_ctrl;

	localparam int SLOT_COUNT = 6;
	localparam int PORTS      = frame_store_pkg::NUM_PORTS;

	logic                      pix_clk_rd;
	logic                      reset;
	logic                      rd_vs;
	logic                      rd_hs;
	logic                      rd_de;
	logic                      wr_slot_valid;
	frame_store_pkg::slot_id_t wr_slot;
	logic                      read_en;
	logic [PORTS-1:0]          rd_port_en;
	logic                      out_vs;
	logic                      out_hs;
	logic                      out_de;
	video_timing_pkg::dim_t    frame_width;
	video_timing_pkg::dim_t    frame_height;
	logic [PORTS-1:0]          rd_req;
	frame_store_pkg::addr_t    rd_addr [PORTS];

	// Driver side state read by the monitor
	logic [15:0]               lfsr_state;
	logic                      random_ctrl;     // Random enables and reports
	logic                      pending_report;
	frame_store_pkg::slot_id_t pending_slot;
	int                        drv_line;
	int                        drv_col;
	video_timing_pkg::dim_t    next_width;
	video_timing_pkg::dim_t    next_height;
	video_timing_pkg::dim_t    model_width;     // Stored geometry after this cycle
	video_timing_pkg::dim_t    model_height;

	// Monitor snapshot of one cycle
	logic                      have_snap;
	int                        base_slot;       // Last reported slot or -1 after reset
	video_timing_pkg::sync_t   snap_sync;
	video_timing_pkg::sync_t   got_sync;
	logic [PORTS-1:0]          snap_req;
	frame_store_pkg::addr_t    snap_addr [PORTS];
	video_timing_pkg::dim_t    snap_width;
	video_timing_pkg::dim_t    snap_height;

	frame_buffer_read_ctrl #(
		.SLOT_COUNT (SLOT_COUNT)
	) u_dut (
		.pix_clk_rd    (pix_clk_rd),
		.reset         (reset),
		.rd_vs         (rd_vs),
		.rd_hs         (rd_hs),
		.rd_de         (rd_de),
		.wr_slot_valid (wr_slot_valid),
		.wr_slot       (wr_slot),
		.read_en       (read_en),
		.rd_port_en    (rd_port_en),
		.out_vs        (out_vs),
		.out_hs        (out_hs),
		.out_de        (out_de),
		.frame_width   (frame_width),
		.frame_height  (frame_height),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr)
	);

	always #2 pix_clk_rd = ~pix_clk_rd;

	// ========================================
	// Reference functions
	// ========================================

	// 16-bit Galois LFSR stepped once per bit
	function automatic logic [15:0] galois_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = galois_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Port j trails reported slot k and keeps the reset table for k < 0
	function automatic frame_store_pkg::addr_t expected_base(input int k, input int j);
		int slot;
		if (k < 0)
			slot = j - 1;
		else
			slot = ((k % SLOT_COUNT) + j + 1) % SLOT_COUNT;
		return frame_store_pkg::addr_t'(slot) * frame_store_pkg::SLOT_STRIDE;
	endfunction

	function automatic frame_store_pkg::addr_t expected_addr(
		input frame_store_pkg::addr_t base, input int line,
		input video_timing_pkg::dim_t width, input int column);
		longint pixel;
		pixel = longint'(line) * longint'(width) + longint'(column);
		return base + frame_store_pkg::addr_t'(pixel * frame_store_pkg::BYTES_PER_PIXEL);
	endfunction

	// ========================================
	// Compare tasks
	// ========================================

	task automatic abort_run;
		$display("sim failed");
		$fatal(1, "stopping on first mismatch");
	endtask

	task automatic check_addr(input frame_store_pkg::addr_t got,
		input frame_store_pkg::addr_t exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_dim(input video_timing_pkg::dim_t got,
		input video_timing_pkg::dim_t exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_sync(input video_timing_pkg::sync_t got,
		input video_timing_pkg::sync_t exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_req(input logic [PORTS-1:0] got, input logic [PORTS-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================

	task automatic drive_cycle(input logic vs, input logic hs, input logic de,
		input int line, input int col);
		logic [31:0] bits;
		@(posedge pix_clk_rd);
		rd_vs <= vs;
		rd_hs <= hs;
		rd_de <= de;
		if (random_ctrl)
		begin
			bits = take_bits(1);
			read_en <= bits[0];
			bits = take_bits(PORTS);
			rd_port_en <= bits[PORTS-1:0];
			if (take_bits(3) == 0)   // Roughly one report in eight cycles
			begin
				bits = take_bits(3);
				pending_slot   = bits[2:0];
				pending_report = 1'b1;
			end
		end
		else
		begin
			read_en    <= 1'b1;
			rd_port_en <= '1;
		end
		wr_slot_valid <= pending_report;
		wr_slot       <= pending_slot;
		pending_report = 1'b0;
		drv_line     = line;
		drv_col      = col;
		model_width  = next_width;
		model_height = next_height;
	endtask

	// W x H active pixels with VS low over the active lines
	task automatic run_frame(input int w, input int h);
		drive_cycle(1'b0, 1'b1, 1'b0, 0, 0);
		drive_cycle(1'b0, 1'b1, 1'b0, 0, 0);
		for (int r = 0; r < h; r++)
		begin
			for (int c = 0; c < w; c++)
				drive_cycle(1'b0, 1'b1, 1'b1, r, c);
			next_width = video_timing_pkg::dim_t'(w);
			drive_cycle(1'b0, 1'b1, 1'b0, r, 0);
			drive_cycle(1'b0, 1'b0, 1'b0, r, 0);   // HS pulse
			drive_cycle(1'b0, 1'b0, 1'b0, r, 0);
			drive_cycle(1'b0, 1'b1, 1'b0, r, 0);
		end
		next_height = video_timing_pkg::dim_t'(h);
		repeat (4)
			drive_cycle(1'b1, 1'b1, 1'b0, 0, 0);
	endtask

	task automatic wait_for_idle_outputs;
		int cycles;
		cycles = 0;
		@(negedge pix_clk_rd);
		while ((rd_req != '0 || out_de) && cycles < 16)
		begin
			@(negedge pix_clk_rd);
			cycles++;
		end
		if (rd_req != '0 || out_de)
		begin
			$display("Timeout: requests did not stop after the last frame");
			abort_run();
		end
	endtask

	// ========================================
	// Monitor
	// ========================================

	always @(negedge pix_clk_rd)
	begin
		if (reset)
		begin
			have_snap = 1'b0;
			base_slot = -1;
		end
		else
		begin
			if (have_snap)
			begin
				got_sync.vs = out_vs;
				got_sync.hs = out_hs;
				got_sync.de = out_de;
				check_sync(got_sync, snap_sync, "registered sync");
				check_req(rd_req, snap_req, "rd_req");
				check_dim(frame_width, snap_width, "frame_width");
				check_dim(frame_height, snap_height, "frame_height");
				for (int j = 0; j < PORTS; j++)
				begin
					if (snap_req[j])
						check_addr(rd_addr[j], snap_addr[j], $sformatf("rd_addr[%0d]", j));
				end
			end
			snap_sync.vs = rd_vs;
			snap_sync.hs = rd_hs;
			snap_sync.de = rd_de;
			for (int j = 0; j < PORTS; j++)
			begin
				snap_req[j]  = rd_de & read_en & rd_port_en[j];
				snap_addr[j] = expected_addr(expected_base(base_slot, j + 1), drv_line,
				                             model_width, drv_col);
			end
			snap_width  = model_width;
			snap_height = model_height;
			if (wr_slot_valid)
				base_slot = int'(wr_slot);   // New bases after the coming edge
			have_snap = 1'b1;
		end
	end

	initial
	begin
		logic [31:0] bits;
		pix_clk_rd     = 1'b0;
		reset          = 1'b1;
		// Busy levels while in reset, so only the reset can give idle outputs
		rd_vs          = 1'b0;
		rd_hs          = 1'b0;
		rd_de          = 1'b1;
		wr_slot_valid  = 1'b1;
		wr_slot        = 3'd5;
		read_en        = 1'b1;
		rd_port_en     = '1;
		lfsr_state     = 16'd96;
		random_ctrl    = 1'b0;
		pending_report = 1'b0;
		pending_slot   = '0;
		drv_line       = 0;
		drv_col        = 0;
		next_width     = video_timing_pkg::RESET_WIDTH;
		next_height    = video_timing_pkg::RESET_HEIGHT;
		model_width    = video_timing_pkg::RESET_WIDTH;
		model_height   = video_timing_pkg::RESET_HEIGHT;
		repeat (2) @(posedge pix_clk_rd);
		reset         <= 1'b0;
		rd_vs         <= 1'b1;
		rd_hs         <= 1'b1;
		rd_de         <= 1'b0;
		wr_slot_valid <= 1'b0;
		wr_slot       <= '0;
		read_en       <= 1'b0;
		rd_port_en    <= '0;

		// Idle levels straight after reset
		@(negedge pix_clk_rd);
		got_sync.vs = out_vs;
		got_sync.hs = out_hs;
		got_sync.de = out_de;
		check_sync(got_sync, video_timing_pkg::SYNC_RESET, "sync after reset");
		check_req(rd_req, '0, "rd_req after reset");
		check_dim(frame_width, video_timing_pkg::RESET_WIDTH, "width after reset");
		check_dim(frame_height, video_timing_pkg::RESET_HEIGHT, "height after reset");

		// One small frame to measure the geometry
		run_frame(24, 6);
		@(negedge pix_clk_rd);
		check_dim(frame_width, 16'd24, "measured width");
		check_dim(frame_height, 16'd6, "measured height");

		// Slot reports seen at line 0, column 0
		for (int i = 0; i < 10; i++)
		begin
			bits = take_bits(3);
			pending_slot   = bits[2:0];
			pending_report = 1'b1;
			run_frame(8, 2);
		end

		random_ctrl = 1'b1;
		run_frame(16, 4);
		run_frame(12, 3);
		run_frame(20, 5);
		random_ctrl = 1'b0;

		wait_for_idle_outputs();
		@(negedge pix_clk_rd);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/frame_store_pkg.sv
hdl/video_timing_pkg.sv
hdl/frame_buffer_ifs.sv
hdl/frame_slot_scheduler.sv
hdl/raster_geometry_meter.sv
hdl/read_request_gen.sv
hdl/frame_buffer_read_ctrl.sv
tests/tb_frame_buffer_read_ctrl.sv

//--- Bender.yml
package:
  name: frame_buffer_read_ctrl

sources:
  - hdl/frame_store_pkg.sv
  - hdl/video_timing_pkg.sv
  - hdl/frame_buffer_ifs.sv
  - hdl/frame_slot_scheduler.sv
  - hdl/raster_geometry_meter.sv
  - hdl/read_request_gen.sv
  - hdl/frame_buffer_read_ctrl.sv
  - target: test
    files:
      - tests/tb_frame_buffer_read_ctrl.sv
